/* all.f */
+incdir+.
stream_pkg.sv
op_pkg.sv
axis_register.sv
stream_decode.sv
stream_execute.sv
stream_result.sv
stream_proc_top.sv
tb_stream_proc.sv

/* run.sh */
#!/bin/sh
# build the stream processor testbench with Verilator and run it
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_stream_proc -Mdir obj_dir -o tb_stream_proc &&
./obj_dir/tb_stream_proc > sim.log 2>&1 ||
{ echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "^No errors$" sim.log && echo "simulation PASSED" ||
{ echo "simulation FAILED"; exit 1; }

/* tb_stream_proc.sv */
/*
 * testbench for the stream command processor
 * clock, reset, lcg stimulus, reference model, output monitor, timeout
 */

`timescale 1ns/1ns

`include "stream_defines.svh"

module tb_stream_proc;

    import stream_pkg::*;
    import op_pkg::*;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    beat_t       in_beat;
    logic        out_valid;
    logic        out_ready;
    beat_t       out_beat;
    logic [15:0] pkt_count;

    // generator states, stimulus and output ready kept apart
    logic [31:0] stim_state;
    logic [31:0] ready_state;

    // model output, packet count and beats still to send
    beat_t       exp_q[$];
    beat_t       send_q[$];
    int          exp_pkts;
    int          beats_sent;

    string       test_name;
    int          test_err_base;
    int          errors;
    int          checks;
    int          cycles;
    bit          bp_mode;

    stream_proc_top u_stream_proc_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat),
        .pkt_count (pkt_count)
    );

    // 40 ns period
    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // upper bits of the lcg state are the better ones
    function automatic logic [15:0] stim_rand();
        stim_state = lcg_step(stim_state);
        return stim_state[31:16];
    endfunction

    function automatic int rand_below(input int n);
        return int'(stim_rand()) % n;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("ERR %s %s expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // header plus n payload beats, model results pushed alongside
    task automatic queue_packet(input opcode_e op, input int n);
        beat_t      b;
        beat_t      e;
        logic [7:0] arg;
        logic [15:0] sum;
        logic [15:0] rnd;
        int         i;
        rnd = stim_rand();
        arg = rnd[`STREAM_ARG_W-1:0];
        // upper header bits random, the decoder should ignore them
        b.data = stim_rand();
        b.data[`STREAM_OP_LSB +: 2] = op;
        b.data[`STREAM_ARG_W-1:0] = arg;
        b.last = (n == 0);
        send_q.push_back(b);
        sum = '0;
        for (i = 0; i < n; i++) begin
            b.data = stim_rand();
            b.last = (i == n - 1);
            send_q.push_back(b);
            e.last = b.last;
            if (op == op_sum) begin
                sum = sum + b.data;
            end else begin
                case (op)
                    op_add:  e.data = b.data + {8'h00, arg};
                    op_xor:  e.data = b.data ^ {arg, arg};
                    default: e.data = b.data;
                endcase
                exp_q.push_back(e);
            end
        end
        // sum packets give a single closing beat
        if (op == op_sum && n > 0) begin
            e.data = sum;
            e.last = 1'b1;
            exp_q.push_back(e);
        end
        if (n > 0) begin
            exp_pkts++;
        end
        beats_sent += n + 1;
    endtask

    // entered on a falling edge, left on the falling edge after the transfer
    task automatic send_beat(input beat_t b);
        bit taken;
        in_valid = 1'b1;
        in_beat  = b;
        taken    = 1'b0;
        while (!taken) begin
            // in_ready is registered, stable until the next rising edge
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic drive_queued(input bit gaps);
        beat_t b;
        int    idle;
        while (send_q.size() != 0) begin
            b = send_q.pop_front();
            if (gaps) begin
                idle = rand_below(3);
                repeat (idle) @(negedge clk);
            end
            send_beat(b);
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    // wait for the model queue to empty, then a few more cycles for strays
    task automatic end_test();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (12) @(negedge clk);
        check_eq("pkt_count", exp_pkts, pkt_count);
        $display("test %s done, %0d mismatches", test_name, errors - test_err_base);
    endtask

    // output side, ready and sampling on the falling edge
    // out_valid does not depend on out_ready, so it can be read after ready is set
    always @(negedge clk) begin
        beat_t e;
        if (bp_mode) begin
            ready_state = lcg_step(ready_state);
            out_ready   = ready_state[31];
        end else begin
            out_ready = 1'b1;
        end
        if (!rst && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("%s: output beat %0h arrived while none was expected",
                         test_name, out_beat);
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_eq("out_beat", e, out_beat);
            end
        end
    end

    // limit grows with the beats queued so far
    always @(posedge clk) begin
        cycles++;
        if (cycles > 8 * beats_sent + 200) begin
            $display("timeout in test %s after %0d cycles, output never drained",
                     test_name, cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int          i;
        int          n;
        logic [15:0] r;
        clk         = 1'b0;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_beat     = '0;
        out_ready   = 1'b1;
        stim_state  = 32'd7;
        ready_state = lcg_step(32'd7);
        exp_pkts    = 0;
        beats_sent  = 0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        bp_mode     = 1'b0;

        // reset held for three rising edges
        start_test("reset");
        repeat (3) begin
            @(negedge clk);
            check_eq("in_ready", 0, in_ready);
            check_eq("out_valid", 0, out_valid);
            check_eq("pkt_count", 0, pkt_count);
        end
        rst = 1'b0;
        check_eq("in_ready", 0, in_ready);
        check_eq("out_valid", 0, out_valid);
        // registered ready comes up one cycle after release
        @(negedge clk);
        check_eq("in_ready", 1, in_ready);
        check_eq("out_valid", 0, out_valid);
        check_eq("pkt_count", 0, pkt_count);
        $display("test %s done, %0d mismatches", test_name, errors - test_err_base);

        start_test("pass_add");
        for (i = 0; i < 12; i++) begin
            r = stim_rand();
            queue_packet(r[0] ? op_add : op_pass, 1 + rand_below(8));
        end
        drive_queued(1'b0);
        end_test();

        start_test("xor_sum");
        for (i = 0; i < 12; i++) begin
            r = stim_rand();
            queue_packet(r[0] ? op_sum : op_xor, 1 + rand_below(8));
        end
        drive_queued(1'b0);
        end_test();

        start_test("backpressure");
        bp_mode = 1'b1;
        for (i = 0; i < 20; i++) begin
            r = stim_rand();
            queue_packet(opcode_e'(r[1:0]), 1 + rand_below(8));
        end
        drive_queued(1'b1);
        end_test();

        // header-only packets among normal ones
        start_test("empty_pkt");
        for (i = 0; i < 16; i++) begin
            r = stim_rand();
            n = (i % 4 == 1 || r[3:2] == 2'd0) ? 0 : 1 + rand_below(8);
            queue_packet(opcode_e'(r[1:0]), n);
        end
        drive_queued(1'b1);
        end_test();

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* stream_proc_top.sv */
/*
 * stream command processor top
 * in register, decode, register, execute, register, result
 */

`timescale 1ns/1ns

module stream_proc_top (
    input  logic              clk,
    input  logic              rst,

    input  logic              in_valid,
    output logic              in_ready,
    input  stream_pkg::beat_t in_beat,

    output logic              out_valid,
    input  logic              out_ready,
    output stream_pkg::beat_t out_beat,

    output logic [15:0]       pkt_count
);

    import stream_pkg::*;
    import op_pkg::*;

    // input register to decode
    logic     in_reg_valid;
    logic     in_reg_ready;
    beat_t    in_reg_beat;

    // decode to its register
    logic     dec_valid;
    logic     dec_ready;
    op_beat_t dec_beat;

    // decode register to execute
    logic     dec_reg_valid;
    logic     dec_reg_ready;
    op_beat_t dec_reg_beat;

    // execute to its register
    logic     exe_valid;
    logic     exe_ready;
    op_beat_t exe_beat;

    // execute register to result
    logic     exe_reg_valid;
    logic     exe_reg_ready;
    op_beat_t exe_reg_beat;

    axis_register #(.payload_t(beat_t)) u_in_reg (
        .clk     (clk),
        .rst     (rst),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .s_data  (in_beat),
        .m_valid (in_reg_valid),
        .m_ready (in_reg_ready),
        .m_data  (in_reg_beat)
    );

    stream_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .s_valid (in_reg_valid),
        .s_ready (in_reg_ready),
        .s_beat  (in_reg_beat),
        .m_valid (dec_valid),
        .m_ready (dec_ready),
        .m_beat  (dec_beat)
    );

    axis_register #(.payload_t(op_beat_t)) u_dec_reg (
        .clk     (clk),
        .rst     (rst),
        .s_valid (dec_valid),
        .s_ready (dec_ready),
        .s_data  (dec_beat),
        .m_valid (dec_reg_valid),
        .m_ready (dec_reg_ready),
        .m_data  (dec_reg_beat)
    );

    stream_execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .s_valid (dec_reg_valid),
        .s_ready (dec_reg_ready),
        .s_beat  (dec_reg_beat),
        .m_valid (exe_valid),
        .m_ready (exe_ready),
        .m_beat  (exe_beat)
    );

    axis_register #(.payload_t(op_beat_t)) u_exe_reg (
        .clk     (clk),
        .rst     (rst),
        .s_valid (exe_valid),
        .s_ready (exe_ready),
        .s_data  (exe_beat),
        .m_valid (exe_reg_valid),
        .m_ready (exe_reg_ready),
        .m_data  (exe_reg_beat)
    );

    stream_result u_result (
        .clk       (clk),
        .rst       (rst),
        .s_valid   (exe_reg_valid),
        .s_ready   (exe_reg_ready),
        .s_beat    (exe_reg_beat),
        .m_valid   (out_valid),
        .m_ready   (out_ready),
        .m_beat    (out_beat),
        .pkt_count (pkt_count)
    );

endmodule

/* stream_result.sv */
/*
 * output stage
 * drops intermediate sum beats, strips the tag, counts packets
 */

`timescale 1ns/1ns

module stream_result (
    input  logic              clk,
    input  logic              rst,

    input  logic              s_valid,
    output logic              s_ready,
    input  op_pkg::op_beat_t  s_beat,

    output logic              m_valid,
    input  logic              m_ready,
    output stream_pkg::beat_t m_beat,

    // packets delivered, wraps
    output logic [15:0]       pkt_count
);

    import op_pkg::*;

    // sum packets only show their final beat
    logic drop;
    logic out_xfer;

    assign drop = (s_beat.opcode == op_sum) && !s_beat.last;

    // dropped beats are swallowed without waiting on downstream
    assign m_valid = s_valid && !drop;
    assign s_ready = m_ready || drop;

    // opcode and argument go no further
    assign m_beat = '{
        data: s_beat.data,
        last: s_beat.last
    };

    assign out_xfer = m_valid && m_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_count <= '0;
        end else if (out_xfer && m_beat.last) begin
            pkt_count <= pkt_count + 16'd1;
        end
    end

endmodule

/* stream_execute.sv */
/*
 * arithmetic stage
 * pass, add, xor or running wrapping sum on each payload beat
 */

`timescale 1ns/1ns

`include "stream_defines.svh"

module stream_execute (
    input  logic             clk,
    input  logic             rst,

    input  logic             s_valid,
    output logic             s_ready,
    input  op_pkg::op_beat_t s_beat,

    output logic             m_valid,
    input  logic             m_ready,
    output op_pkg::op_beat_t m_beat
);

    import op_pkg::*;

    // running sum of the current sum packet
    logic [`STREAM_DATA_W-1:0] acc;
    logic [`STREAM_DATA_W-1:0] acc_sum;

    // argument widened two ways
    logic [`STREAM_DATA_W-1:0] arg_ext;
    logic [`STREAM_DATA_W-1:0] arg_rep;

    logic                      xfer;

    // no buffering here, handshake is straight through
    assign s_ready = m_ready;
    assign m_valid = s_valid;
    assign xfer    = s_valid && m_ready;

    assign arg_ext = {{(`STREAM_DATA_W - `STREAM_ARG_W){1'b0}}, s_beat.arg};
    assign arg_rep = {2{s_beat.arg}};
    // sum includes the beat being presented, wraps at 16 bits
    assign acc_sum = acc + s_beat.data;

    always_comb begin
        m_beat = s_beat;
        case (s_beat.opcode)
            op_pass: m_beat.data = s_beat.data;
            op_add:  m_beat.data = s_beat.data + arg_ext;
            op_xor:  m_beat.data = s_beat.data ^ arg_rep;
            op_sum:  m_beat.data = acc_sum;
            default: m_beat.data = s_beat.data;
        endcase
    end

    // cleared at packet end whatever the opcode
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (xfer && s_beat.last) begin
            acc <= '0;
        end else if (xfer && (s_beat.opcode == op_sum)) begin
            acc <= acc_sum;
        end
    end

endmodule

/* stream_decode.sv */
/*
 * header parser
 * strips the header beat, tags payload beats with opcode and argument
 */

`timescale 1ns/1ns

`include "stream_defines.svh"

module stream_decode (
    input  logic              clk,
    input  logic              rst,

    // raw beats in
    input  logic              s_valid,
    output logic              s_ready,
    input  stream_pkg::beat_t s_beat,

    // tagged beats out
    output logic              m_valid,
    input  logic              m_ready,
    output op_pkg::op_beat_t  m_beat
);

    import stream_pkg::*;
    import op_pkg::*;

    dec_state_e               state;

    // header fields held for the rest of the packet
    opcode_e                  op_q;
    logic [`STREAM_ARG_W-1:0] arg_q;

    // header beat seen, always taken
    logic                     hdr_take;
    logic                     xfer;

    assign hdr_take = s_valid && (state == st_header);
    assign xfer     = s_valid && s_ready;

    // header is consumed locally, payload waits on downstream
    assign s_ready = (state == st_header) ? 1'b1 : m_ready;
    assign m_valid = s_valid && (state == st_payload);

    // payload tagged with the latched header
    assign m_beat = '{
        opcode: op_q,
        arg:    arg_q,
        data:   s_beat.data,
        last:   s_beat.last
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_header;
        end else if (xfer) begin
            case (state)
                // header with last is an empty packet, stay here
                st_header: begin
                    if (!s_beat.last) begin
                        state <= st_payload;
                    end
                end
                st_payload: begin
                    if (s_beat.last) begin
                        state <= st_header;
                    end
                end
                default: state <= st_header;
            endcase
        end
    end

    // opcode sits above the argument in the header
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            op_q  <= opcode_e'(s_beat.data[`STREAM_OP_LSB +: $bits(opcode_e)]);
            arg_q <= s_beat.data[`STREAM_ARG_W-1:0];
        end
    end

endmodule

/* axis_register.sv */
/*
 * axi4-stream style register with skid entry
 * registered ready, full throughput, payload as one struct
 */

`timescale 1ns/1ns

module axis_register #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst,

    // sink side
    input  logic     s_valid,
    output logic     s_ready,
    input  payload_t s_data,

    // source side
    output logic     m_valid,
    input  logic     m_ready,
    output payload_t m_data
);

    // skid entry, filled when output stalls while ready was still high
    logic     tmp_valid;
    payload_t tmp_data;

    // next state of the valid flags
    logic     m_valid_next;
    logic     tmp_valid_next;

    // data movement strobes
    logic     store_in_to_out;
    logic     store_in_to_tmp;
    logic     store_tmp_to_out;

    // ready for next cycle
    // high if output drains, or the skid entry cannot fill this cycle
    logic     ready_early;

    assign ready_early = m_ready | (~tmp_valid & (~m_valid | ~s_valid));

    always_comb begin
        m_valid_next     = m_valid;
        tmp_valid_next   = tmp_valid;
        store_in_to_out  = 1'b0;
        store_in_to_tmp  = 1'b0;
        store_tmp_to_out = 1'b0;

        if (s_ready) begin
            if (m_ready || !m_valid) begin
                // output empty or draining, load it straight from input
                m_valid_next    = s_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat in the skid entry
                tmp_valid_next  = s_valid;
                store_in_to_tmp = 1'b1;
            end
        end else if (m_ready) begin
            // input blocked, move skid entry forward
            m_valid_next     = tmp_valid;
            tmp_valid_next   = 1'b0;
            store_tmp_to_out = 1'b1;
        end
    end

    // control flags
    always_ff @(posedge clk) begin
        if (rst) begin
            s_ready   <= 1'b0;
            m_valid   <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            s_ready   <= ready_early;
            m_valid   <= m_valid_next;
            tmp_valid <= tmp_valid_next;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_data <= s_data;
        end else if (store_tmp_to_out) begin
            m_data <= tmp_data;
        end

        if (store_in_to_tmp) begin
            tmp_data <= s_data;
        end
    end

endmodule

/* op_pkg.sv */
/*
 * operation types for the command pipeline
 * opcode enum, decoder state enum, tagged operation beat
 */

`include "stream_defines.svh"

package op_pkg;

    // header opcodes, values fixed by the header format
    typedef enum logic [1:0] {
        op_pass = 2'd0,
        op_add  = 2'd1,
        op_xor  = 2'd2,
        op_sum  = 2'd3
    } opcode_e;

    // decoder position within a packet
    typedef enum logic {
        st_header  = 1'b0,
        st_payload = 1'b1
    } dec_state_e;

    // payload beat tagged with the header that owns it
    typedef struct packed {
        opcode_e                   opcode;
        logic [`STREAM_ARG_W-1:0]  arg;
        logic [`STREAM_DATA_W-1:0] data;
        logic                      last;
    } op_beat_t;

endpackage

/* stream_pkg.sv */
/*
 * raw stream types
 * beat_t carries one data word and the packet end flag
 */

`include "stream_defines.svh"

package stream_pkg;

    // one beat as seen on the external ports
    // last marks the final beat of a packet
    typedef struct packed {
        logic [`STREAM_DATA_W-1:0] data;
        logic                      last;
    } beat_t;

endpackage

/* stream_defines.svh */
/*
 * shared width macros for the stream command processor
 * beat data width, header argument width, opcode field position
 */

`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// width of every beat on the stream
`define STREAM_DATA_W 16

// header argument, taken from the low bits of the header beat
`define STREAM_ARG_W 8

// lsb of the 2-bit opcode field inside the header beat
// the argument occupies the bits below it
`define STREAM_OP_LSB 8

`endif
